// ==== include/stream_cfg_consts.svh ====
`ifndef STREAM_CFG_CONSTS_SVH
`define STREAM_CFG_CONSTS_SVH

// ------------------------------
// Widths
// ------------------------------
`define STREAM_NUM_CHANNELS 8
`define STREAM_APB_ADDR_W 12
`define STREAM_APB_DATA_W 32
`define STREAM_DESC_ADDR_W 64
`define STREAM_CHAN_W 3

// ------------------------------
// Address map
// ------------------------------
// Kick-off region is 0x000 up to here, one word per channel
`define STREAM_KICK_LAST 12'h01F
`define STREAM_REGS_BASE 12'h100
`define STREAM_REG_GLOBAL_CTRL 12'h100
`define STREAM_REG_CHAN_EN 12'h104
`define STREAM_REG_DESC_HI 12'h108

// Register reset values
`define STREAM_RST_GLOBAL_EN 1'b1
`define STREAM_RST_CHAN_EN 8'hFF

`endif

// ==== rtl/stream_cfg_pkg.sv ====
`include "stream_cfg_consts.svh"

package stream_cfg_pkg;

    // ------------------------------
    // Command / response transport
    // ------------------------------

    // One APB access, as seen after the bridge
    typedef struct packed {
        logic                              write;
        logic [`STREAM_APB_ADDR_W-1:0]     addr;
        logic [`STREAM_APB_DATA_W-1:0]     wdata;
        logic [`STREAM_APB_DATA_W/8-1:0]   strb;
    } apb_cmd_t;

    // Answer to one command
    typedef struct packed {
        logic [`STREAM_APB_DATA_W-1:0]     rdata;
        logic                              err;
    } apb_rsp_t;

    // ------------------------------
    // Kick stream
    // ------------------------------

    // Channel number plus full descriptor address
    typedef struct packed {
        logic [`STREAM_CHAN_W-1:0]         chan;
        logic [`STREAM_DESC_ADDR_W-1:0]    addr;
    } desc_kick_t;

endpackage

// ==== rtl/apb_cmd_bridge.sv ====
`timescale 1ns/1ps
`include "stream_cfg_consts.svh"

module apb_cmd_bridge (
    input  logic                              aclk,
    input  logic                              arst_n,
    // APB4 slave
    input  logic [`STREAM_APB_ADDR_W-1:0]     paddr,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [`STREAM_APB_DATA_W-1:0]     pwdata,
    input  logic [`STREAM_APB_DATA_W/8-1:0]   pstrb,
    output logic [`STREAM_APB_DATA_W-1:0]     prdata,
    output logic                              pready,
    output logic                              pslverr,
    // Command out, response back
    output logic                              cmd_valid,
    input  logic                              cmd_ready,
    output stream_cfg_pkg::apb_cmd_t          cmd,
    input  logic                              rsp_valid,
    output logic                              rsp_ready,
    input  stream_cfg_pkg::apb_rsp_t          rsp
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CMD,
        ST_WAIT
    } state_e;

    state_e state;
    logic   access;

    // Access phase not yet answered
    // pready high means the current one just finished
    assign access = psel && penable && !pready;

    assign cmd_valid = (state == ST_CMD);
    assign rsp_ready = (state == ST_WAIT);

    // ------------------------------
    // FSM and pready
    // ------------------------------
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= ST_IDLE;
            pready <= 1'b0;
        end else begin
            pready <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (access) begin
                        state <= ST_CMD;
                    end
                end
                ST_CMD: begin
                    // Single outstanding command
                    if (cmd_ready) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (rsp_valid) begin
                        state  <= ST_IDLE;
                        pready <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Capture access, then response
    always_ff @(posedge aclk) begin
        if (state == ST_IDLE && access) begin
            cmd.write <= pwrite;
            cmd.addr  <= paddr;
            cmd.wdata <= pwdata;
            cmd.strb  <= pstrb;
        end
        if (rsp_valid && rsp_ready) begin
            prdata  <= rsp.rdata;
            pslverr <= rsp.err;
        end
    end

endmodule

// ==== rtl/cmd_addr_demux.sv ====
`timescale 1ns/1ps
`include "stream_cfg_consts.svh"

module cmd_addr_demux (
    input  logic                      aclk,
    input  logic                      arst_n,
    // From the bridge
    input  logic                      cmd_valid,
    output logic                      cmd_ready,
    input  stream_cfg_pkg::apb_cmd_t  cmd,
    output logic                      rsp_valid,
    input  logic                      rsp_ready,
    output stream_cfg_pkg::apb_rsp_t  rsp,
    // Kick-off region
    output logic                      kick_cmd_valid,
    input  logic                      kick_cmd_ready,
    output stream_cfg_pkg::apb_cmd_t  kick_cmd,
    input  logic                      kick_rsp_valid,
    output logic                      kick_rsp_ready,
    input  stream_cfg_pkg::apb_rsp_t  kick_rsp,
    // Register region
    output logic                      reg_cmd_valid,
    input  logic                      reg_cmd_ready,
    output stream_cfg_pkg::apb_cmd_t  reg_cmd,
    input  logic                      reg_rsp_valid,
    output logic                      reg_rsp_ready,
    input  stream_cfg_pkg::apb_rsp_t  reg_rsp
);

    typedef enum logic [1:0] {
        TGT_KICK,
        TGT_REG,
        TGT_HOLE
    } target_e;

    target_e cmd_tgt;
    target_e rsp_tgt;
    logic    hole_rsp_valid;

    // ------------------------------
    // Decode and command steering
    // ------------------------------
    always_comb begin
        if (cmd.addr <= `STREAM_KICK_LAST) begin
            cmd_tgt = TGT_KICK;
        end else if (cmd.addr >= `STREAM_REGS_BASE) begin
            cmd_tgt = TGT_REG;
        end else begin
            // 0x020..0x0FF, answered locally
            cmd_tgt = TGT_HOLE;
        end
    end

    assign kick_cmd_valid = cmd_valid && (cmd_tgt == TGT_KICK);
    assign reg_cmd_valid  = cmd_valid && (cmd_tgt == TGT_REG);
    assign kick_cmd       = cmd;
    assign reg_cmd        = cmd;

    always_comb begin
        case (cmd_tgt)
            TGT_KICK: cmd_ready = kick_cmd_ready;
            TGT_REG:  cmd_ready = reg_cmd_ready;
            default:  cmd_ready = !hole_rsp_valid;
        endcase
    end

    // Remember target for response, and the hole error
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_tgt        <= TGT_HOLE;
            hole_rsp_valid <= 1'b0;
        end else begin
            if (cmd_valid && cmd_ready) begin
                rsp_tgt        <= cmd_tgt;
                hole_rsp_valid <= (cmd_tgt == TGT_HOLE);
            end else if (hole_rsp_valid && rsp_ready) begin
                hole_rsp_valid <= 1'b0;
            end
        end
    end

    // ------------------------------
    // Response return
    // ------------------------------
    always_comb begin
        kick_rsp_ready = 1'b0;
        reg_rsp_ready  = 1'b0;
        case (rsp_tgt)
            TGT_KICK: begin
                rsp_valid      = kick_rsp_valid;
                rsp            = kick_rsp;
                kick_rsp_ready = rsp_ready;
            end
            TGT_REG: begin
                rsp_valid     = reg_rsp_valid;
                rsp           = reg_rsp;
                reg_rsp_ready = rsp_ready;
            end
            default: begin
                // Decode error, data zero
                rsp_valid = hole_rsp_valid;
                rsp.rdata = '0;
                rsp.err   = 1'b1;
            end
        endcase
    end

endmodule

// ==== rtl/desc_kickoff.sv ====
`timescale 1ns/1ps
`include "stream_cfg_consts.svh"

module desc_kickoff (
    input  logic                                          aclk,
    input  logic                                          arst_n,
    // Command / response
    input  logic                                          cmd_valid,
    output logic                                          cmd_ready,
    input  stream_cfg_pkg::apb_cmd_t                      cmd,
    output logic                                          rsp_valid,
    input  logic                                          rsp_ready,
    output stream_cfg_pkg::apb_rsp_t                      rsp,
    // Enables and upper address from the registers
    input  logic                                          global_en,
    input  logic [`STREAM_NUM_CHANNELS-1:0]               chan_en,
    input  logic [`STREAM_DESC_ADDR_W-`STREAM_APB_DATA_W-1:0] desc_hi,
    // Kick stream
    output logic                                          kick_valid,
    input  logic                                          kick_ready,
    output stream_cfg_pkg::desc_kick_t                    kick
);

    logic [`STREAM_CHAN_W-1:0] cmd_chan;
    logic                      kick_ok;
    logic                      accept;
    logic                      rsp_err;

    // One word per channel
    assign cmd_chan = cmd.addr[`STREAM_CHAN_W+1:2];

    // Write only, both enables needed
    assign kick_ok = cmd.write && global_en && chan_en[cmd_chan];

    // Nothing new while a kick or an answer is pending
    assign cmd_ready = !kick_valid && !rsp_valid;
    assign accept    = cmd_valid && cmd_ready;

    // ------------------------------
    // Kick and response control
    // ------------------------------
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            kick_valid <= 1'b0;
            rsp_valid  <= 1'b0;
        end else begin
            if (accept) begin
                if (kick_ok) begin
                    kick_valid <= 1'b1;
                end else begin
                    // Rejected, answer right away
                    rsp_valid <= 1'b1;
                end
            end
            // APB side waits until the kick is gone
            if (kick_valid && kick_ready) begin
                kick_valid <= 1'b0;
                rsp_valid  <= 1'b1;
            end
            if (rsp_valid && rsp_ready) begin
                rsp_valid <= 1'b0;
            end
        end
    end

    // Payload, held while kick_valid waits
    always_ff @(posedge aclk) begin
        if (accept) begin
            kick.chan <= cmd_chan;
            kick.addr <= {desc_hi, cmd.wdata};
            rsp_err   <= !kick_ok;
        end
    end

    // Region is write-only
    assign rsp.rdata = '0;
    assign rsp.err   = rsp_err;

endmodule

// ==== rtl/stream_ctrl_regs.sv ====
`timescale 1ns/1ps
`include "stream_cfg_consts.svh"

module stream_ctrl_regs (
    input  logic                                          aclk,
    input  logic                                          arst_n,
    // Command / response
    input  logic                                          cmd_valid,
    output logic                                          cmd_ready,
    input  stream_cfg_pkg::apb_cmd_t                      cmd,
    output logic                                          rsp_valid,
    input  logic                                          rsp_ready,
    output stream_cfg_pkg::apb_rsp_t                      rsp,
    // Register outputs
    output logic                                          global_en,
    output logic [`STREAM_NUM_CHANNELS-1:0]               chan_en,
    output logic [`STREAM_DESC_ADDR_W-`STREAM_APB_DATA_W-1:0] desc_hi
);

    logic                          accept;
    logic                          addr_hit;
    logic [`STREAM_APB_DATA_W-1:0] rd_data;

    assign cmd_ready = !rsp_valid;
    assign accept    = cmd_valid && cmd_ready;

    // ------------------------------
    // Read decode
    // ------------------------------
    always_comb begin
        addr_hit = 1'b1;
        rd_data  = '0;
        case (cmd.addr)
            `STREAM_REG_GLOBAL_CTRL: rd_data[0] = global_en;
            `STREAM_REG_CHAN_EN:     rd_data[`STREAM_NUM_CHANNELS-1:0] = chan_en;
            `STREAM_REG_DESC_HI:     rd_data = desc_hi;
            default:                 addr_hit = 1'b0;
        endcase
    end

    // Registers and response valid
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            global_en <= `STREAM_RST_GLOBAL_EN;
            chan_en   <= `STREAM_RST_CHAN_EN;
            desc_hi   <= '0;
            rsp_valid <= 1'b0;
        end else begin
            if (accept && cmd.write) begin
                // Byte strobes apply per field
                case (cmd.addr)
                    `STREAM_REG_GLOBAL_CTRL: if (cmd.strb[0]) global_en <= cmd.wdata[0];
                    `STREAM_REG_CHAN_EN:     if (cmd.strb[0]) chan_en <= cmd.wdata[7:0];
                    `STREAM_REG_DESC_HI: begin
                        for (int b = 0; b < `STREAM_APB_DATA_W / 8; b++) begin
                            if (cmd.strb[b]) desc_hi[8*b +: 8] <= cmd.wdata[8*b +: 8];
                        end
                    end
                    default: ;
                endcase
            end
            if (accept) begin
                rsp_valid <= 1'b1;
            end else if (rsp_ready) begin
                rsp_valid <= 1'b0;
            end
        end
    end

    // Undefined address gives error and zero
    always_ff @(posedge aclk) begin
        if (accept) begin
            rsp.rdata <= (addr_hit && !cmd.write) ? rd_data : '0;
            rsp.err   <= !addr_hit;
        end
    end

endmodule

// ==== rtl/stream_apb_top.sv ====
`timescale 1ns/1ps
`include "stream_cfg_consts.svh"

module stream_apb_top (
    input  logic                              aclk,
    input  logic                              arst_n,
    // APB4 configuration port
    input  logic [`STREAM_APB_ADDR_W-1:0]     paddr,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [`STREAM_APB_DATA_W-1:0]     pwdata,
    input  logic [`STREAM_APB_DATA_W/8-1:0]   pstrb,
    output logic [`STREAM_APB_DATA_W-1:0]     prdata,
    output logic                              pready,
    output logic                              pslverr,
    // Descriptor kicks
    output logic                              kick_valid,
    input  logic                              kick_ready,
    output stream_cfg_pkg::desc_kick_t        kick
);

    import stream_cfg_pkg::*;

    // ------------------------------
    // Bridge <-> demux
    // ------------------------------
    logic     cmd_valid;
    logic     cmd_ready;
    apb_cmd_t cmd;
    logic     rsp_valid;
    logic     rsp_ready;
    apb_rsp_t rsp;

    // Demux <-> targets
    logic     kick_cmd_valid;
    logic     kick_cmd_ready;
    apb_cmd_t kick_cmd;
    logic     kick_rsp_valid;
    logic     kick_rsp_ready;
    apb_rsp_t kick_rsp;
    logic     reg_cmd_valid;
    logic     reg_cmd_ready;
    apb_cmd_t reg_cmd;
    logic     reg_rsp_valid;
    logic     reg_rsp_ready;
    apb_rsp_t reg_rsp;

    // Register levels into kick-off
    logic                                          global_en;
    logic [`STREAM_NUM_CHANNELS-1:0]               chan_en;
    logic [`STREAM_DESC_ADDR_W-`STREAM_APB_DATA_W-1:0] desc_hi;

    apb_cmd_bridge u_bridge (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .pstrb     (pstrb),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd       (cmd),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

    // Kick-off at 0x000, registers from 0x100
    cmd_addr_demux u_demux (
        .aclk           (aclk),
        .arst_n         (arst_n),
        .cmd_valid      (cmd_valid),
        .cmd_ready      (cmd_ready),
        .cmd            (cmd),
        .rsp_valid      (rsp_valid),
        .rsp_ready      (rsp_ready),
        .rsp            (rsp),
        .kick_cmd_valid (kick_cmd_valid),
        .kick_cmd_ready (kick_cmd_ready),
        .kick_cmd       (kick_cmd),
        .kick_rsp_valid (kick_rsp_valid),
        .kick_rsp_ready (kick_rsp_ready),
        .kick_rsp       (kick_rsp),
        .reg_cmd_valid  (reg_cmd_valid),
        .reg_cmd_ready  (reg_cmd_ready),
        .reg_cmd        (reg_cmd),
        .reg_rsp_valid  (reg_rsp_valid),
        .reg_rsp_ready  (reg_rsp_ready),
        .reg_rsp        (reg_rsp)
    );

    desc_kickoff u_kickoff (
        .aclk       (aclk),
        .arst_n     (arst_n),
        .cmd_valid  (kick_cmd_valid),
        .cmd_ready  (kick_cmd_ready),
        .cmd        (kick_cmd),
        .rsp_valid  (kick_rsp_valid),
        .rsp_ready  (kick_rsp_ready),
        .rsp        (kick_rsp),
        .global_en  (global_en),
        .chan_en    (chan_en),
        .desc_hi    (desc_hi),
        .kick_valid (kick_valid),
        .kick_ready (kick_ready),
        .kick       (kick)
    );

    stream_ctrl_regs u_regs (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .cmd_valid (reg_cmd_valid),
        .cmd_ready (reg_cmd_ready),
        .cmd       (reg_cmd),
        .rsp_valid (reg_rsp_valid),
        .rsp_ready (reg_rsp_ready),
        .rsp       (reg_rsp),
        .global_en (global_en),
        .chan_en   (chan_en),
        .desc_hi   (desc_hi)
    );

endmodule

// ==== verif/stream_apb_checker.sv ====
`timescale 1ns/1ps

module stream_apb_checker (
    input logic                       aclk,
    input logic                       arst_n,
    input logic                       psel,
    input logic                       penable,
    input logic                       pready,
    input logic                       kick_valid,
    input logic                       kick_ready,
    input stream_cfg_pkg::desc_kick_t kick
);

    // Failed assertions so far, read by the testbench at the end
    int assert_fails = 0;

    // ------------------------------
    // Kick stream handshake
    // ------------------------------
    // Payload frozen while waiting for ready
    kick_hold: assert property (@(posedge aclk) disable iff (!arst_n)
        kick_valid && !kick_ready |=> kick_valid && $stable(kick))
    else begin
        $error("kick dropped or changed before kick_ready");
        assert_fails++;
    end

    // ------------------------------
    // APB completion
    // ------------------------------
    pready_in_access: assert property (@(posedge aclk) disable iff (!arst_n)
        pready |-> psel && penable)
    else begin
        $error("pready high outside an APB access phase");
        assert_fails++;
    end

endmodule

bind stream_apb_top stream_apb_checker u_checker (
    .aclk       (aclk),
    .arst_n     (arst_n),
    .psel       (psel),
    .penable    (penable),
    .pready     (pready),
    .kick_valid (kick_valid),
    .kick_ready (kick_ready),
    .kick       (kick)
);

// ==== verif/stream_apb_tb.sv ====
`timescale 1ns/1ps
`include "stream_cfg_consts.svh"

module stream_apb_tb;

    import stream_cfg_pkg::*;

    localparam int    clk_half        = 2;
    localparam int    rst_cycles      = 16;
    localparam int    cycles_per_line = 200;
    localparam string stim_file       = "verif/stream_apb_stim.txt";

    logic                              aclk;
    logic                              arst_n;
    logic [`STREAM_APB_ADDR_W-1:0]     paddr;
    logic                              psel;
    logic                              penable;
    logic                              pwrite;
    logic [`STREAM_APB_DATA_W-1:0]     pwdata;
    logic [`STREAM_APB_DATA_W/8-1:0]   pstrb;
    logic [`STREAM_APB_DATA_W-1:0]     prdata;
    logic                              pready;
    logic                              pslverr;
    logic                              kick_valid;
    logic                              kick_ready;
    desc_kick_t                        kick;

    // Stimulus table, one entry per file line
    logic        stim_wr[$];
    logic [11:0] stim_addr[$];
    logic [31:0] stim_data[$];
    logic [3:0]  stim_strb[$];
    logic [31:0] stim_rdata[$];
    logic        stim_err[$];
    int          num_lines   = 0;
    bit          stim_loaded = 1'b0;

    // Register model
    logic        model_global_en;
    logic [7:0]  model_chan_en;
    logic [31:0] model_desc_hi;

    // Kick scoreboard and counts
    desc_kick_t  exp_kicks[$];
    int          kicks_seen   = 0;
    int          err_count    = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    logic [31:0] rng_state;

    stream_apb_top DUT (
        .aclk       (aclk),
        .arst_n     (arst_n),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .pstrb      (pstrb),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .kick_valid (kick_valid),
        .kick_ready (kick_ready),
        .kick       (kick)
    );

    initial begin
        aclk = 1'b0;
        forever #clk_half aclk = ~aclk;
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Write to kick-off region with both enables set
    function automatic logic predict_kick(input logic wr, input logic [11:0] addr);
        return wr && (addr <= `STREAM_KICK_LAST) && model_global_en
            && model_chan_en[addr[4:2]];
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("MISMATCH at %0d ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        err_count++;
    endtask

    task automatic update_model(input logic [11:0] addr, input logic [31:0] data,
                                input logic [3:0] strb);
        case (addr)
            `STREAM_REG_GLOBAL_CTRL: begin
                if (strb[0]) begin
                    model_global_en = data[0];
                end
            end
            `STREAM_REG_CHAN_EN: begin
                if (strb[0]) begin
                    model_chan_en = data[7:0];
                end
            end
            `STREAM_REG_DESC_HI: begin
                for (int b = 0; b < 4; b++) begin
                    if (strb[b]) begin
                        model_desc_hi[8*b +: 8] = data[8*b +: 8];
                    end
                end
            end
            default: ;
        endcase
    endtask

    task automatic load_stim();
        int          fd;
        string       line;
        logic [31:0] f_wr;
        logic [31:0] f_addr;
        logic [31:0] f_data;
        logic [31:0] f_strb;
        logic [31:0] f_rdata;
        logic [31:0] f_err;
        fd = $fopen(stim_file, "r");
        if (fd == 0) begin
            $display("ERROR: cannot open stimulus file %s", stim_file);
            err_count++;
        end else begin
            while ($fgets(line, fd) > 0) begin
                // Skip comment and blank lines
                if (line.len() > 0 && line.getc(0) != "#" && $sscanf(line,
                    "%h %h %h %h %h %h", f_wr, f_addr, f_data, f_strb, f_rdata, f_err) == 6) begin
                    stim_wr.push_back(f_wr[0]);
                    stim_addr.push_back(f_addr[11:0]);
                    stim_data.push_back(f_data);
                    stim_strb.push_back(f_strb[3:0]);
                    stim_rdata.push_back(f_rdata);
                    stim_err.push_back(f_err[0]);
                end
            end
            $fclose(fd);
        end
        num_lines   = stim_wr.size();
        stim_loaded = 1'b1;
    endtask

    // Full APB access, called on a falling edge
    task automatic apb_access(input logic wr, input logic [11:0] addr,
                              input logic [31:0] data, input logic [3:0] strb,
                              output logic [31:0] rdata, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        pstrb   = strb;
        @(negedge aclk);
        penable = 1'b1;
        // Access phase held until pready
        @(negedge aclk);
        while (!pready) begin
            @(negedge aclk);
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge aclk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic run_line(input int idx);
        logic [31:0] rdata;
        logic        err;
        logic        kick_exp;
        logic        kick_wr;
        int          errs_before;
        int          kicks_before;
        desc_kick_t  exp;
        errs_before  = err_count;
        kicks_before = kicks_seen;
        kick_wr      = stim_wr[idx] && (stim_addr[idx] <= `STREAM_KICK_LAST);
        kick_exp     = predict_kick(stim_wr[idx], stim_addr[idx]);
        if (kick_wr && (kick_exp == stim_err[idx])) begin
            $display("ERROR at %0d ns: line %0d, register model and stimulus file disagree",
                     $time, idx);
            err_count++;
        end
        if (kick_exp) begin
            exp.chan = stim_addr[idx][4:2];
            exp.addr = {model_desc_hi, stim_data[idx]};
            exp_kicks.push_back(exp);
        end
        apb_access(stim_wr[idx], stim_addr[idx], stim_data[idx], stim_strb[idx], rdata, err);
        if (err !== stim_err[idx]) begin
            report_mismatch("pslverr", 64'(err), 64'(stim_err[idx]));
        end
        if (rdata !== stim_rdata[idx]) begin
            report_mismatch("prdata", 64'(rdata), 64'(stim_rdata[idx]));
        end
        // Kick must be gone before pready, and only one
        if (kicks_seen != kicks_before + (kick_exp ? 1 : 0)) begin
            $display("ERROR at %0d ns: line %0d completed after %0d kicks, expected %0d",
                     $time, idx, kicks_seen - kicks_before, kick_exp ? 1 : 0);
            err_count++;
        end
        if (stim_wr[idx] && !stim_err[idx] && stim_addr[idx] >= `STREAM_REGS_BASE) begin
            update_model(stim_addr[idx], stim_data[idx], stim_strb[idx]);
        end
        tests_run++;
        if (err_count == errs_before) begin
            $display("test %0d %s 0x%03h: pass", idx, stim_wr[idx] ? "write" : "read",
                     stim_addr[idx]);
        end else begin
            tests_failed++;
            $display("test %0d %s 0x%03h: FAIL", idx, stim_wr[idx] ? "write" : "read",
                     stim_addr[idx]);
        end
    endtask

    // ------------------------------
    // Kick side: random ready, scoreboard
    // ------------------------------
    initial begin : kick_side
        desc_kick_t exp;
        kick_ready = 1'b0;
        rng_state  = 32'h8d75_a3e2;
        forever begin
            @(negedge aclk);
            rng_state  = lcg_next(rng_state);
            kick_ready = rng_state[31];
            // Transfer happens on the coming rising edge
            if (arst_n && kick_valid && kick_ready) begin
                kicks_seen++;
                if (exp_kicks.size() == 0) begin
                    $display("ERROR at %0d ns: unexpected kick on channel %0d",
                             $time, kick.chan);
                    err_count++;
                end else begin
                    exp = exp_kicks.pop_front();
                    if (kick.chan !== exp.chan) begin
                        report_mismatch("kick.chan", 64'(kick.chan), 64'(exp.chan));
                    end
                    if (kick.addr !== exp.addr) begin
                        report_mismatch("kick.addr", kick.addr, exp.addr);
                    end
                end
            end
        end
    end

    // Budget scales with the stimulus length
    initial begin : watchdog
        wait (stim_loaded);
        repeat (rst_cycles + (num_lines + 1) * cycles_per_line) @(posedge aclk);
        $display("ERROR: watchdog expired, DUT stopped answering APB accesses");
        $display("Test failed");
        $finish;
    end

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin : main
        arst_n          = 1'b0;
        paddr           = '0;
        psel            = 1'b0;
        penable         = 1'b0;
        pwrite          = 1'b0;
        pwdata          = '0;
        pstrb           = '0;
        model_global_en = `STREAM_RST_GLOBAL_EN;
        model_chan_en   = `STREAM_RST_CHAN_EN;
        model_desc_hi   = '0;
        load_stim();
        if (num_lines == 0) begin
            $display("ERROR: no stimulus lines read");
            err_count++;
        end
        repeat (rst_cycles) @(negedge aclk);
        arst_n = 1'b1;
        repeat (2) @(negedge aclk);
        for (int i = 0; i < num_lines; i++) begin
            run_line(i);
        end
        repeat (10) @(negedge aclk);
        if (exp_kicks.size() != 0) begin
            $display("ERROR: %0d predicted kicks never transferred", exp_kicks.size());
            err_count++;
        end
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d kicks, %0d assertion failures",
                 tests_run, tests_run - tests_failed, tests_failed, kicks_seen,
                 DUT.u_checker.assert_fails);
        if (err_count == 0 && DUT.u_checker.assert_fails == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+include
rtl/stream_cfg_pkg.sv
rtl/apb_cmd_bridge.sv
rtl/cmd_addr_demux.sv
rtl/desc_kickoff.sv
rtl/stream_ctrl_regs.sv
rtl/stream_apb_top.sv
verif/stream_apb_checker.sv
verif/stream_apb_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the STREAM APB front-end testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module stream_apb_tb \
    -f filelist.f -o Vstream_apb_tb > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/Vstream_apb_tb +verilator+error+limit+1000 > sim.log 2>&1 \
    || { cat sim.log; echo "Simulation exited abnormally"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0

// ==== verif/stream_apb_stim.txt ====
# wr addr data strb exp_rdata exp_err, all hex, wr 1 is a write
# Kicks are not listed here, the testbench predicts them from its register model
0 100 00000000 0 00000001 0
0 104 00000000 0 000000ff 0
0 108 00000000 0 00000000 0
1 108 a5a51234 f 00000000 0
1 108 11227788 2 00000000 0
0 108 00000000 0 a5a57734 0
1 000 10000000 f 00000000 0
1 01c 20000040 f 00000000 0
1 00c 30000080 f 00000000 0
1 104 000000f7 1 00000000 0
0 104 00000000 0 000000f7 0
1 00c 40000000 f 00000000 1
1 010 50000000 f 00000000 0
1 100 00000000 1 00000000 0
0 100 00000000 0 00000000 0
1 004 60000000 f 00000000 1
0 000 00000000 0 00000000 1
0 020 00000000 0 00000000 1
1 0fc 12345678 f 00000000 1
0 10c 00000000 0 00000000 1
1 100 00000001 1 00000000 0
1 014 70000100 f 00000000 0
1 018 80000200 f 00000000 0
1 018 80000300 f 00000000 0
